//--- pov_pkg.sv
`default_nettype none

package pov_pkg;

    // image geometry
    localparam int NUM_ROWS  = 16;  // rows per column
    localparam int NUM_COLS  = 16;  // image columns around the circle
    localparam int SCAN_RATE = 8;   // pairs per sweep, also face offset
    localparam int THETA_RES = 8;   // angle sensor bits
    localparam int RGB_RES   = 9;   // 3r 3g 3b, red on top

    localparam int COL_BITS  = $clog2(NUM_COLS);
    localparam int PAIR_BITS = $clog2(SCAN_RATE);

    typedef logic [THETA_RES-1:0]        theta_t;
    typedef logic [COL_BITS-1:0]         slot_t;      // top bits of theta
    typedef logic [COL_BITS-1:0]         col_idx_t;
    typedef logic [PAIR_BITS-1:0]        pair_idx_t;
    typedef logic [RGB_RES-1:0]          pixel_t;
    typedef logic [NUM_ROWS*RGB_RES-1:0] column_t;    // row 0 in low bits

    // colours shared by the pattern generators
    localparam pixel_t PIX_RED   = 9'h1c0;
    localparam pixel_t PIX_GREEN = 9'h038;
    localparam pixel_t PIX_BLUE  = 9'h007;
    localparam pixel_t PIX_WHITE = 9'h1ff;

    typedef enum logic [1:0] {
        MODE_BLANK   = 2'd0,
        MODE_SPHERE  = 2'd1,
        MODE_CUBE    = 2'd2,
        MODE_OVERLAY = 2'd3   // sphere | cube
    } mode_t;

    typedef enum logic {
        FM_IDLE  = 1'b0,      // waiting for a slot
        FM_SWEEP = 1'b1       // serving pairs on ready
    } fm_state_t;

    // one column pair for the panel, 296 bits
    typedef struct packed {
        col_idx_t col_num1;   // front face image column
        col_idx_t col_num2;   // opposite face, col_num1 + 8
        column_t  col1;
        column_t  col2;
    } col_pair_t;

endpackage

`default_nettype wire

//--- angle_tracker.sv
`timescale 1ns/1ps
`default_nettype none

// turns the raw theta strobe into a slot change pulse
module angle_tracker
    import pov_pkg::*;
(
    input  logic   clk_in,
    input  logic   rst_in,
    input  theta_t theta,        // angle from sensor
    input  logic   theta_valid,  // one cycle strobe
    output logic   new_slot,     // pulse on slot change
    output slot_t  slot          // current angular slot
);

    slot_t theta_slot;  // slot of the incoming sample
    logic  seen_first;  // any theta since reset
    logic  slot_change;

    // top bits of theta pick the slot
    assign theta_slot = theta[THETA_RES-1 -: COL_BITS];

    // first sample always counts as a change
    assign slot_change = theta_valid && (!seen_first || (theta_slot != slot));

    // control flags
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            seen_first <= 1'b0;
            new_slot   <= 1'b0;
        end else begin
            new_slot <= slot_change;  // one cycle only
            if (theta_valid) begin
                seen_first <= 1'b1;
            end
        end
    end

    // stored slot
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            slot <= '0;
        end else if (slot_change) begin
            slot <= theta_slot;  // valid with new_slot
        end
    end

endmodule

`default_nettype wire

//--- sphere_frame.sv
`timescale 1ns/1ps
`default_nettype none

// sphere pattern, latitude bands plus two meridians
module sphere_frame
    import pov_pkg::*;
(
    input  col_idx_t col_num1,
    input  col_idx_t col_num2,
    output column_t  col1,
    output column_t  col2
);

    // one image column of the sphere
    function automatic column_t paint_sphere(input col_idx_t c);
        column_t col;
        pixel_t  px;
        logic    meridian;
        col      = '0;
        meridian = (c == 4'd0) || (c == 4'd8);  // front and back meridian
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (meridian) begin
                px = PIX_WHITE;
            end else if (r < 4) begin
                px = PIX_RED;    // north cap
            end else if (r < 12) begin
                px = PIX_GREEN;  // equator band
            end else begin
                px = PIX_BLUE;   // south cap
            end
            col[r*RGB_RES +: RGB_RES] = px;
        end
        return col;
    endfunction

    // both faces share the same painter
    always_comb begin
        col1 = paint_sphere(col_num1);
        col2 = paint_sphere(col_num2);
    end

endmodule

`default_nettype wire

//--- cube_frame.sv
`timescale 1ns/1ps
`default_nettype none

// cube outline, top and bottom edges plus four vertical edges
module cube_frame
    import pov_pkg::*;
(
    input  col_idx_t col_num1,
    input  col_idx_t col_num2,
    output column_t  col1,
    output column_t  col2
);

    function automatic column_t paint_cube(input col_idx_t c);
        column_t col;
        logic    edge_col;
        col      = '0;
        // columns 2, 6, 10, 14 are the vertical edges
        edge_col = (c[1:0] == 2'b10);
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (edge_col || r == 0 || r == NUM_ROWS-1) begin
                col[r*RGB_RES +: RGB_RES] = PIX_WHITE;
            end
            // everything else stays dark
        end
        return col;
    endfunction

    always_comb begin
        col1 = paint_cube(col_num1);
        col2 = paint_cube(col_num2);  // opposite face
    end

endmodule

`default_nettype wire

//--- frame_manager.sv
`timescale 1ns/1ps
`default_nettype none

// sweep control, one registered column pair per ready pulse
module frame_manager
    import pov_pkg::*;
(
    input  logic      clk_in,
    input  logic      rst_in,
    input  mode_t     mode,         // sampled with ready
    input  logic      new_slot,     // pulse from tracker
    input  slot_t     slot,
    input  logic      hub75_ready,  // one cycle pulse from panel driver
    output col_idx_t  next_num1,    // to generators
    output col_idx_t  next_num2,
    input  column_t   sphere_col1,
    input  column_t   sphere_col2,
    input  column_t   cube_col1,
    input  column_t   cube_col2,
    output col_pair_t pair,
    output logic      data_valid,
    output logic      sweep_done    // with the 8th pair
);

    fm_state_t state;
    slot_t     sweep_slot;  // slot latched at sweep start
    pair_idx_t pair_cnt;    // pair k within the sweep
    logic      pend_valid;  // slot arrived mid sweep
    slot_t     pend_slot;   // latest such slot
    logic      last_pair;
    column_t   sel_col1;
    column_t   sel_col2;

    // column indices follow slot and k, wrap at 16
    assign next_num1 = col_idx_t'(sweep_slot) + col_idx_t'(pair_cnt);
    assign next_num2 = next_num1 + col_idx_t'(SCAN_RATE);  // opposite face

    assign last_pair = (pair_cnt == pair_idx_t'(SCAN_RATE-1));

    // pattern select by mode
    always_comb begin
        sel_col1 = '0;  // blank
        sel_col2 = '0;
        case (mode)
            MODE_SPHERE: begin
                sel_col1 = sphere_col1;
                sel_col2 = sphere_col2;
            end
            MODE_CUBE: begin
                sel_col1 = cube_col1;
                sel_col2 = cube_col2;
            end
            MODE_OVERLAY: begin
                sel_col1 = sphere_col1 | cube_col1;  // draw both
                sel_col2 = sphere_col2 | cube_col2;
            end
            default: ;
        endcase
    end

    // fsm and output pair
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state      <= FM_IDLE;
            pair_cnt   <= '0;
            pend_valid <= 1'b0;
            data_valid <= 1'b0;
            sweep_done <= 1'b0;
            pair       <= '0;
        end else begin
            data_valid <= 1'b0;  // strobes last one cycle
            sweep_done <= 1'b0;
            case (state)
                FM_IDLE: begin
                    // ready ignored here
                    if (new_slot || pend_valid) begin
                        pair_cnt   <= '0;
                        pend_valid <= 1'b0;  // consumed
                        state      <= FM_SWEEP;
                    end
                end
                FM_SWEEP: begin
                    if (new_slot) begin
                        pend_valid <= 1'b1;  // hold for next sweep
                    end
                    if (hub75_ready) begin
                        pair.col_num1 <= next_num1;
                        pair.col_num2 <= next_num2;
                        pair.col1     <= sel_col1;
                        pair.col2     <= sel_col2;
                        data_valid    <= 1'b1;
                        pair_cnt      <= pair_cnt + 1'b1;
                        if (last_pair) begin
                            sweep_done <= 1'b1;
                            state      <= FM_IDLE;  // pending slot restarts next cycle
                        end
                    end
                end
                default: state <= FM_IDLE;
            endcase
        end
    end

    // slot registers
    always_ff @(posedge clk_in) begin
        if (state == FM_IDLE) begin
            if (new_slot) begin
                sweep_slot <= slot;       // fresh slot beats pending
            end else if (pend_valid) begin
                sweep_slot <= pend_slot;
            end
        end else if (new_slot) begin
            pend_slot <= slot;            // latest wins
        end
    end

endmodule

`default_nettype wire

//--- pov_top.sv
`timescale 1ns/1ps
`default_nettype none

// pov column feeder, theta in, column pairs out
module pov_top
    import pov_pkg::*;
(
    input  logic      clk_in,
    input  logic      rst_in,
    input  theta_t    theta,
    input  logic      theta_valid,
    input  mode_t     mode,
    input  logic      hub75_ready,
    output col_pair_t pair,
    output logic      data_valid,
    output logic      sweep_done
);

    logic     new_slot;
    slot_t    slot;
    col_idx_t next_num1;
    col_idx_t next_num2;
    column_t  sphere_col1;
    column_t  sphere_col2;
    column_t  cube_col1;
    column_t  cube_col2;

    angle_tracker u_tracker (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .theta       (theta),
        .theta_valid (theta_valid),
        .new_slot    (new_slot),
        .slot        (slot)
    );

    frame_manager u_manager (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .mode        (mode),
        .new_slot    (new_slot),
        .slot        (slot),
        .hub75_ready (hub75_ready),
        .next_num1   (next_num1),
        .next_num2   (next_num2),
        .sphere_col1 (sphere_col1),
        .sphere_col2 (sphere_col2),
        .cube_col1   (cube_col1),
        .cube_col2   (cube_col2),
        .pair        (pair),
        .data_valid  (data_valid),
        .sweep_done  (sweep_done)
    );

    // both generators see the same pair of indices
    sphere_frame u_sphere (
        .col_num1 (next_num1),
        .col_num2 (next_num2),
        .col1     (sphere_col1),
        .col2     (sphere_col2)
    );

    cube_frame u_cube (
        .col_num1 (next_num1),
        .col_num2 (next_num2),
        .col1     (cube_col1),
        .col2     (cube_col2)
    );

endmodule

`default_nettype wire

//--- pov_sva.sv
`timescale 1ns/1ps
`default_nettype none

// output timing rules of frame_manager
module pov_sva
    import pov_pkg::*;
(
    input logic      clk_in,
    input logic      rst_in,
    input logic      hub75_ready,
    input logic      data_valid,
    input logic      sweep_done,
    input col_pair_t pair
);

    int err_count = 0;  // failed assertions so far

    a_valid_after_ready: assert property (@(posedge clk_in) disable iff (rst_in)
        data_valid |-> $past(hub75_ready))
        else begin
            err_count = err_count + 1;
            $error("data_valid without ready one cycle before");
        end

    // faces sit half a turn apart
    a_opposite_face: assert property (@(posedge clk_in) disable iff (rst_in)
        data_valid |-> (pair.col_num2 == col_idx_t'(pair.col_num1 + 4'd8)))
        else begin
            err_count = err_count + 1;
            $error("col_num2 is not col_num1 plus 8");
        end

    a_done_with_valid: assert property (@(posedge clk_in) disable iff (rst_in)
        sweep_done |-> data_valid)
        else begin
            err_count = err_count + 1;
            $error("sweep_done without data_valid");
        end

    a_back_to_back: assert property (@(posedge clk_in) disable iff (rst_in)
        (data_valid && $past(data_valid)) |-> ($past(hub75_ready) && $past(hub75_ready, 2)))
        else begin
            err_count = err_count + 1;
            $error("two data_valid cycles without two ready cycles");
        end

endmodule

bind frame_manager pov_sva u_sva (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .hub75_ready (hub75_ready),
    .data_valid  (data_valid),
    .sweep_done  (sweep_done),
    .pair        (pair)
);

`default_nettype wire

//--- tb_pov_top.sv
`timescale 1ns/1ps
`default_nettype none

// directed testbench for the pov column feeder
module tb_pov_top
    import pov_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;  // about ten times the whole run

    logic        clk_in;
    logic        rst_in;
    theta_t      theta;
    logic        theta_valid;
    mode_t       mode;
    logic        hub75_ready;
    col_pair_t   pair;
    logic        data_valid;
    logic        sweep_done;
    logic [31:0] lfsr_state;
    int          cycle_count;

    pov_top uut (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .theta       (theta),
        .theta_valid (theta_valid),
        .mode        (mode),
        .hub75_ready (hub75_ready),
        .pair        (pair),
        .data_valid  (data_valid),
        .sweep_done  (sweep_done)
    );

    always #5 clk_in = ~clk_in;  // 10 ns period

    // watchdog
    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_count);
            $display("Simulation failed");
            $fatal(1, "run stopped by the watchdog");
        end
    end

    // bound timing checker, any failure ends the run
    always @(negedge clk_in) begin
        assert (uut.u_manager.u_sva.err_count == 0) else begin
            $display("a timing assertion in the bound checker failed");
            $display("Simulation failed");
            $fatal(1, "stopped at the first error");
        end
    end

    // x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);  // one step per bit
            bits       = {bits[6:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // expected column straight from the image rules
    function automatic column_t ref_column(input int c, input mode_t m);
        column_t col;
        pixel_t  sph;
        pixel_t  cub;
        col = '0;
        for (int r = 0; r < 16; r++) begin
            sph = (c == 0 || c == 8) ? PIX_WHITE :
                  (r < 4) ? PIX_RED : (r < 12) ? PIX_GREEN : PIX_BLUE;
            cub = (r == 0 || r == 15 || c % 4 == 2) ? PIX_WHITE : 9'h000;  // edges
            case (m)
                MODE_SPHERE:  col[r*9 +: 9] = sph;
                MODE_CUBE:    col[r*9 +: 9] = cub;
                MODE_OVERLAY: col[r*9 +: 9] = sph | cub;
                default:      col[r*9 +: 9] = 9'h000;
            endcase
        end
        return col;
    endfunction

    // pair k of a sweep that started at slot s
    function automatic col_pair_t ref_pair(input int s, input int k, input mode_t m);
        col_pair_t p;
        int        c1;
        int        c2;
        c1         = (s + k) % 16;
        c2         = (c1 + 8) % 16;  // opposite face
        p.col_num1 = col_idx_t'(c1);
        p.col_num2 = col_idx_t'(c2);
        p.col1     = ref_column(c1, m);
        p.col2     = ref_column(c2, m);
        return p;
    endfunction

    task automatic report_mismatch(input string name, input logic [295:0] exp_v,
                                   input logic [295:0] act_v);
        $display("error: %s expected %0h, got %0h", name, exp_v, act_v);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_in);
            hub75_ready <= 1'b0;
            @(negedge clk_in);
            assert (data_valid === 1'b0) else report_mismatch("data_valid", 0, data_valid);
            assert (sweep_done === 1'b0) else report_mismatch("sweep_done", 0, sweep_done);
        end
    endtask

    task automatic send_theta(input theta_t th);
        @(posedge clk_in);
        theta       <= th;
        theta_valid <= 1'b1;
        @(posedge clk_in);                      // tracker samples the strobe
        theta_valid <= 1'b0;
        theta       <= theta_t'(take_bits(8));  // junk while not strobed
    endtask

    // one ready pulse, answer expected one cycle later or not at all
    task automatic pulse_ready(input mode_t m, input logic answered, input int s, input int k);
        col_pair_t exp_p;
        logic      exp_done;
        @(posedge clk_in);
        hub75_ready <= 1'b1;
        mode        <= m;
        @(posedge clk_in);                     // ready and mode sampled here
        hub75_ready <= 1'b0;
        mode        <= mode_t'(take_bits(2));  // later mode must not leak in
        @(negedge clk_in);
        exp_done = answered && (k == 7);
        exp_p    = ref_pair(s, k, m);
        assert (data_valid === answered) else report_mismatch("data_valid", answered, data_valid);
        assert (sweep_done === exp_done) else report_mismatch("sweep_done", exp_done, sweep_done);
        if (answered) begin
            assert (pair === exp_p) else report_mismatch("pair", exp_p, pair);
        end
    endtask

    // pairs first_k..last_k, random ready gaps, optional mode change per pair
    task automatic run_sweep(input int s, input mode_t m, input logic vary,
                             input int first_k, input int last_k);
        mode_t mk;
        for (int k = first_k; k <= last_k; k++) begin
            mk = vary ? mode_t'(take_bits(2)) : m;
            idle_cycles(int'(take_bits(2)));
            pulse_ready(mk, 1'b1, s, k);
        end
    endtask

    task automatic reset_idle();
        @(negedge clk_in);
        assert (data_valid === 1'b0) else report_mismatch("data_valid", 0, data_valid);
        assert (sweep_done === 1'b0) else report_mismatch("sweep_done", 0, sweep_done);
        assert (pair === '0) else report_mismatch("pair", 0, pair);
        assert (uut.new_slot === 1'b0) else report_mismatch("new_slot", 0, uut.new_slot);
        repeat (4) pulse_ready(MODE_SPHERE, 1'b0, 0, 0);  // no slot yet
    endtask

    task automatic sphere_sweep();
        send_theta(8'h35);  // slot 3
        run_sweep(3, MODE_SPHERE, 1'b0, 0, 7);
        idle_cycles(2);
    endtask

    task automatic same_slot_ignored();
        send_theta(8'h3a);  // still slot 3
        @(negedge clk_in);
        assert (uut.new_slot === 1'b0) else report_mismatch("new_slot", 0, uut.new_slot);
        repeat (4) pulse_ready(MODE_CUBE, 1'b0, 0, 0);
    endtask

    task automatic mode_sweeps();
        send_theta(8'h72);
        run_sweep(7, MODE_CUBE, 1'b0, 0, 7);
        send_theta(8'hc4);
        run_sweep(12, MODE_BLANK, 1'b0, 0, 7);
        send_theta(8'hf1);
        run_sweep(15, MODE_OVERLAY, 1'b0, 0, 7);
        send_theta(8'h0e);
        run_sweep(0, MODE_SPHERE, 1'b1, 0, 7);  // mode moves between pairs
    endtask

    task automatic pending_slot_kept();
        send_theta(8'h50);
        run_sweep(5, MODE_SPHERE, 1'b0, 0, 2);
        send_theta(8'h97);                      // slot 9 held
        run_sweep(5, MODE_CUBE, 1'b0, 3, 4);
        send_theta(8'hd3);                      // slot 13 replaces it
        run_sweep(5, MODE_OVERLAY, 1'b0, 5, 7);
        run_sweep(13, MODE_SPHERE, 1'b1, 0, 7); // the single follow-up sweep
        idle_cycles(3);
        repeat (4) pulse_ready(MODE_SPHERE, 1'b0, 0, 0);
    endtask

    initial begin
        clk_in      = 1'b0;
        rst_in      = 1'b1;
        theta       = '0;
        theta_valid = 1'b0;
        mode        = MODE_BLANK;
        hub75_ready = 1'b0;
        lfsr_state  = 32'h780c2ace;
        cycle_count = 0;
        repeat (16) @(posedge clk_in);
        rst_in <= 1'b0;
        reset_idle();
        sphere_sweep();
        same_slot_ignored();
        mode_sweeps();
        pending_slot_kept();
        if (uut.u_manager.u_sva.err_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("a timing assertion in the bound checker failed");
            $display("Simulation failed");
            $fatal(1, "stopped at the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- sources.f
pov_pkg.sv
angle_tracker.sv
sphere_frame.sv
cube_frame.sv
frame_manager.sv
pov_top.sv
pov_sva.sv
tb_pov_top.sv

//--- Bender.yml
package:
  name: pov_feeder

sources:
  - pov_pkg.sv
  - angle_tracker.sv
  - sphere_frame.sv
  - cube_frame.sv
  - frame_manager.sv
  - pov_top.sv
  - target: simulation
    files:
      - pov_sva.sv
      - tb_pov_top.sv
